// ==== tb.f ====
src/lvdcPkg.sv
src/serialLoader.sv
src/timingGen.sv
src/coreMemory.sv
src/transferRegister.sv
src/opCodeReg.sv
src/serialArithmetic.sv
src/accDisplay.sv
src/lvdcTop.sv
dv/lvdcTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module lvdcTb -f tb.f -o lvdcSim &&
./obj_dir/lvdcSim > sim.log 2>&1 ||
{ echo "build or run error"; exit 1; }
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation ok" ||
{ echo "simulation reported failure"; exit 1; }

// ==== dv/lvdcTb.sv ====
module lvdcTb;
    import lvdcPkg::*;

    logic  clk;
    logic  reset;
    logic  start;
    logic  halt;
    logic  dataIn;
    logic  dataValid;
    logic  running;
    word_t accValue;
    logic  accStrobe;

    word_t       refMem [memWords];  // Mirror of the DUT memory.
    word_t       prog [64];
    word_t       expVals [256];
    word_t       modelAcc;
    int          expCount;
    int          strobeCount;
    int          gapCount;
    int          stopStrobes;
    int          errors;
    logic        haveStrobe;
    logic        timedOut;
    logic [31:0] lfsrState;
    string       testName;

    lvdcTop u_dut (.*);

    always #2 clk = ~clk;

    // ************************************************************
    // Strobe bookkeeping and checks
    // ************************************************************
    always @(posedge clk) begin
        if (reset) begin
            strobeCount <= 0;
            gapCount    <= 0;
            stopStrobes <= 0;
            haveStrobe  <= 1'b0;
        end else begin
            gapCount <= accStrobe ? 1 : gapCount + 1;
            if (accStrobe) begin
                strobeCount <= strobeCount + 1;
            end
            if (start) begin
                haveStrobe <= 1'b0;  // First strobe of a run has no predecessor.
            end else if (accStrobe) begin
                haveStrobe <= 1'b1;
            end
            stopStrobes <= running ? 0 : stopStrobes + int'(accStrobe);
        end
    end

    strobeValueCheck: assert property (@(negedge clk) disable iff (reset)
        accStrobe |-> (strobeCount < expCount) && (accValue == expVals[strobeCount]))
    else begin
        errors++;
        if (strobeCount >= expCount) begin
            $display("accStrobe appeared with no predicted result in %s", testName);
        end else begin
            $display("mismatch %s: expected %h, actual %h", testName,
                     expVals[strobeCount], accValue);
        end
    end

    strobeSpacingCheck: assert property (@(negedge clk) disable iff (reset)
        (accStrobe && haveStrobe) |-> gapCount == 26)
    else begin
        errors++;
        $display("mismatch %s strobe spacing: expected 26, actual %0d", testName, gapCount);
    end

    haltQuietCheck: assert property (@(negedge clk) disable iff (reset)
        (accStrobe && !running) |-> stopStrobes == 0)
    else begin
        errors++;
        $display("accStrobe appeared after the machine had halted in %s", testName);
    end

    startRiseCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(running) == $past(start && !running))
    else begin
        errors++;
        $display("running did not rise exactly one cycle after start in %s", testName);
    end

    function automatic logic nextBit();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    function automatic word_t randWord();
        word_t w;
        for (int b = 0; b < wordBits; b++) begin
            w[b] = nextBit();
        end
        return w;
    endfunction

    task automatic waitStrobes(input int target);
        int n;
        n = 0;
        while (strobeCount < target && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (strobeCount < target) begin
            timedOut = 1'b1;
            $display("timed out waiting for accStrobe in %s", testName);
        end
    endtask

    task automatic waitStopped();
        int n;
        n = 0;
        while (running && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (running) begin
            timedOut = 1'b1;
            $display("timed out waiting for running to fall in %s", testName);
        end
    endtask

    task automatic loadProgram(input int len);
        if (timedOut) return;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < wordBits; b++) begin
                @(negedge clk);
                dataIn    = prog[i][b];  // LSB first.
                dataValid = 1'b1;
            end
            refMem[i] = prog[i];
        end
        @(negedge clk);
        dataValid = 1'b0;
        repeat (2) @(negedge clk);
        foreach (prog[i]) begin
            prog[i] = '0;
        end
    endtask

    // ************************************************************
    // Reference model, one result per executed instruction
    // ************************************************************
    task automatic predictRun(input int maxSteps);
        addr_t   pc;
        word_t   w;
        opcode_t op;
        addr_t   a;
        logic    done;
        pc   = '0;
        done = 1'b0;
        for (int step = 0; step < maxSteps && !done; step++) begin
            w  = refMem[pc];
            op = w[wordBits-1:addrBits];
            a  = w[addrBits-1:0];
            pc = pc + 1'b1;
            case (op)
                opHalt:          done = 1'b1;
                opClearAdd:      modelAcc = refMem[a];
                opAdd:           modelAcc = modelAcc + refMem[a];
                opSub:           modelAcc = modelAcc - refMem[a];
                opAnd:           modelAcc = modelAcc & refMem[a];
                opStore:         refMem[a] = modelAcc;
                opTransfer:      pc = a;
                opTransferMinus: pc = modelAcc[wordBits-1] ? a : pc;
                default:         ;
            endcase
            expVals[expCount] = modelAcc;
            expCount++;
        end
    endtask

    // A haltAfter of 0 runs until the halt opcode.
    task automatic runProgram(input string name, input int haltAfter, input bit noise);
        int base;
        if (timedOut) return;
        base     = expCount;
        testName = name;
        predictRun(64);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (noise) begin
            repeat (30) begin
                @(negedge clk);
                dataValid = 1'b1;  // Dropped while running.
                dataIn    = nextBit();
            end
            @(negedge clk);
            dataValid = 1'b0;
        end
        if (haltAfter > 0) begin
            waitStrobes(base + haltAfter);
            halt = 1'b1;
        end
        waitStopped();
        halt = 1'b0;
        if (timedOut) return;
        repeat (60) @(negedge clk);
        if (haltAfter > 0) begin
            expCount = base + haltAfter + 1;  // Held halt ends the next instruction.
        end
        assert (strobeCount == expCount) else begin
            errors++;
            $display("mismatch %s strobe count: expected %0d, actual %0d", name,
                     expCount, strobeCount);
        end
        modelAcc = expVals[expCount-1];
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        halt      = 1'b0;
        dataIn    = 1'b0;
        dataValid = 1'b0;
        errors    = 0;
        expCount  = 0;
        modelAcc  = '0;
        timedOut  = 1'b0;
        lfsrState = 32'h4bdfc964;
        testName  = "reset";
        foreach (prog[i]) begin
            prog[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Arithmetic, a no-op, and store then reload.
        prog[0]  = {opClearAdd, 9'd16};
        prog[1]  = {opAdd, 9'd17};
        prog[2]  = {opSub, 9'd18};
        prog[3]  = {opAnd, 9'd19};
        prog[4]  = {opAdd, 9'd20};
        prog[5]  = {4'd9, 9'd17};
        prog[6]  = {opStore, 9'd22};
        prog[7]  = {opClearAdd, 9'd21};
        prog[8]  = {opClearAdd, 9'd22};
        prog[9]  = {opSub, 9'd20};
        prog[10] = {opHalt, 9'd0};
        for (int i = 16; i < 23; i++) begin
            prog[i] = randWord();
        end
        loadProgram(23);
        runProgram("arith and store", 0, 1'b0);

        prog[0]  = {opClearAdd, 9'd16};
        prog[1]  = {opTransfer, 9'd3};
        prog[2]  = {opAdd, 9'd18};  // Skipped.
        prog[3]  = {opTransferMinus, 9'd2};
        prog[4]  = {opClearAdd, 9'd17};
        prog[5]  = {opTransferMinus, 9'd7};
        prog[6]  = {opAdd, 9'd18};
        prog[7]  = {opAdd, 9'd18};
        prog[8]  = {opHalt, 9'd0};
        prog[16] = randWord() & 13'h0fff;  // Positive.
        prog[17] = randWord() | 13'h1000;  // Negative.
        prog[18] = randWord();
        loadProgram(19);
        runProgram("transfers", 0, 1'b0);

        // Endless loop, stopped by the halt input.
        prog[0] = {opClearAdd, 9'd16};
        prog[1] = {opAdd, 9'd17};
        prog[2] = {opSub, 9'd18};
        prog[3] = {opTransfer, 9'd1};
        for (int i = 16; i < 19; i++) begin
            prog[i] = randWord();
        end
        loadProgram(19);
        runProgram("held halt", 5, 1'b0);
        runProgram("restart with noise", 4, 1'b1);
        runProgram("memory after noise", 3, 1'b0);

        $display("errors %0d, strobes %0d, timeouts %0d", errors, strobeCount, timedOut);
        if (errors == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src/lvdcTop.sv ====
module lvdcTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           halt,
    input  logic           dataIn,
    input  logic           dataValid,
    output logic           running,
    output lvdcPkg::word_t accValue,
    output logic           accStrobe
);
    import lvdcPkg::*;

    memWrite_t loadWrite;
    memWrite_t storeWrite;
    timing_t   timing;
    addr_t     readAddr;
    addr_t     pcAddr;
    word_t     readData;
    instr_t    fetchedInstr;
    instr_t    instr;
    logic      operandBit;
    logic      haltRequest;
    logic      accBit;
    logic      accSign;

    // ************************************************************
    // Input side
    // ************************************************************
    serialLoader uSerialLoader (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dataIn    (dataIn),
        .dataValid (dataValid),
        .timing    (timing),
        .loadWrite (loadWrite)
    );

    // ************************************************************
    // Processing
    // ************************************************************
    timingGen uTimingGen (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .halt        (halt),
        .haltRequest (haltRequest),
        .timing      (timing),
        .running     (running)
    );

    coreMemory uCoreMemory (
        .clk        (clk),
        .loadWrite  (loadWrite),
        .storeWrite (storeWrite),
        .readAddr   (readAddr),
        .readData   (readData)
    );

    transferRegister uTransferRegister (
        .clk          (clk),
        .reset        (reset),
        .timing       (timing),
        .instr        (instr),
        .pcAddr       (pcAddr),
        .accBit       (accBit),
        .readData     (readData),
        .readAddr     (readAddr),
        .fetchedInstr (fetchedInstr),
        .operandBit   (operandBit),
        .storeWrite   (storeWrite)
    );

    opCodeReg uOpCodeReg (
        .clk          (clk),
        .reset        (reset),
        .timing       (timing),
        .start        (start),
        .fetchedInstr (fetchedInstr),
        .accSign      (accSign),
        .instr        (instr),
        .pcAddr       (pcAddr),
        .haltRequest  (haltRequest)
    );

    serialArithmetic uSerialArithmetic (
        .clk        (clk),
        .reset      (reset),
        .timing     (timing),
        .instr      (instr),
        .operandBit (operandBit),
        .accBit     (accBit),
        .accSign    (accSign)
    );

    // Output side.
    accDisplay uAccDisplay (
        .clk       (clk),
        .reset     (reset),
        .timing    (timing),
        .accBit    (accBit),
        .accValue  (accValue),
        .accStrobe (accStrobe)
    );

endmodule

// ==== src/accDisplay.sv ====
module accDisplay (
    input  logic             clk,
    input  logic             reset,
    input  lvdcPkg::timing_t timing,
    input  logic             accBit,
    output lvdcPkg::word_t   accValue,
    output logic             accStrobe
);
    import lvdcPkg::*;

    word_t capture;
    logic  execEnd;

    assign execEnd = timing.execPhase && timing.wordEnd;

    always_ff @(posedge clk) begin
        if (timing.execPhase) begin
            capture <= {accBit, capture[wordBits-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accValue  <= '0;
            accStrobe <= 1'b0;
        end else begin
            accStrobe <= execEnd;
            if (execEnd) begin
                accValue <= {accBit, capture[wordBits-1:1]};  // Include final bit.
            end
        end
    end

endmodule

// ==== src/serialArithmetic.sv ====
module serialArithmetic (
    input  logic             clk,
    input  logic             reset,
    input  lvdcPkg::timing_t timing,
    input  lvdcPkg::instr_t  instr,
    input  logic             operandBit,
    output logic             accBit,
    output logic             accSign
);
    import lvdcPkg::*;

    word_t acc;  // Recirculating loop, LSB leaves first.
    logic  carry;
    logic  carryIn;
    logic  addend;
    logic  sumBit;
    logic  carryOut;
    logic  resultBit;
    logic  signReg;

    // Subtract is add of the inverted operand plus one.
    assign carryIn  = timing.wordStart ? (instr.opcode == opSub) : carry;
    assign addend   = (instr.opcode == opSub) ? ~operandBit : operandBit;
    assign sumBit   = acc[0] ^ addend ^ carryIn;
    assign carryOut = (acc[0] & addend) | (carryIn & (acc[0] ^ addend));

    always_comb begin
        case (instr.opcode)
            opClearAdd:   resultBit = operandBit;
            opAdd, opSub: resultBit = sumBit;
            opAnd:        resultBit = operandBit & acc[0];
            default:      resultBit = acc[0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc     <= '0;
            carry   <= 1'b0;
            signReg <= 1'b0;
        end else if (timing.execPhase) begin
            acc   <= {resultBit, acc[wordBits-1:1]};
            carry <= carryOut;
            if (timing.wordEnd) begin
                signReg <= resultBit;  // Last bit is the sign.
            end
        end
    end

    assign accBit  = resultBit;
    assign accSign = signReg;

endmodule

// ==== src/opCodeReg.sv ====
module opCodeReg (
    input  logic             clk,
    input  logic             reset,
    input  lvdcPkg::timing_t timing,
    input  logic             start,
    input  lvdcPkg::instr_t  fetchedInstr,
    input  logic             accSign,
    output lvdcPkg::instr_t  instr,
    output lvdcPkg::addr_t   pcAddr,
    output logic             haltRequest
);
    import lvdcPkg::*;

    logic fetchEnd;
    logic execEnd;
    logic takeBranch;

    assign fetchEnd = !timing.execPhase && timing.wordEnd;
    assign execEnd  = timing.execPhase && timing.wordEnd;

    assign takeBranch = (instr.opcode == opTransfer) ||
                        ((instr.opcode == opTransferMinus) && accSign);

    assign haltRequest = execEnd && (instr.opcode == opHalt);

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (fetchEnd) begin
            instr <= fetchedInstr;
        end
    end

    // ************************************************************
    // Instruction location counter
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pcAddr <= '0;
        end else if (start && !timing.running) begin
            pcAddr <= '0;
        end else if (execEnd) begin
            pcAddr <= takeBranch ? instr.address : pcAddr + 1'b1;
        end
    end

endmodule

// ==== src/transferRegister.sv ====
module transferRegister (
    input  logic               clk,
    input  logic               reset,
    input  lvdcPkg::timing_t   timing,
    input  lvdcPkg::instr_t    instr,
    input  lvdcPkg::addr_t     pcAddr,
    input  logic               accBit,
    input  lvdcPkg::word_t     readData,
    output lvdcPkg::addr_t     readAddr,
    output lvdcPkg::instr_t    fetchedInstr,
    output logic               operandBit,
    output lvdcPkg::memWrite_t storeWrite
);
    import lvdcPkg::*;

    word_t shiftReg;
    word_t srcWord;
    logic  isStore;
    logic  inBit;

    assign readAddr = timing.execPhase ? instr.address : pcAddr;

    // At word start the memory word is used directly.
    assign srcWord    = timing.wordStart ? readData : shiftReg;
    assign operandBit = srcWord[0];
    assign isStore    = (instr.opcode == opStore);
    assign inBit      = isStore ? accBit : srcWord[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            shiftReg <= '0;
        end else if (timing.execPhase) begin
            shiftReg <= {inBit, srcWord[wordBits-1:1]};  // One bit per cycle.
        end else if (timing.wordStart) begin
            shiftReg <= readData;  // Instruction word.
        end
    end

    assign fetchedInstr = instr_t'(shiftReg);

    // ************************************************************
    // Store write-back at the end of the execute word
    // ************************************************************
    assign storeWrite.enable  = timing.execPhase && timing.wordEnd && isStore;
    assign storeWrite.address = instr.address;
    assign storeWrite.data    = {accBit, shiftReg[wordBits-1:1]};

endmodule

// ==== src/coreMemory.sv ====
module coreMemory (
    input  logic               clk,
    input  lvdcPkg::memWrite_t loadWrite,
    input  lvdcPkg::memWrite_t storeWrite,
    input  lvdcPkg::addr_t     readAddr,
    output lvdcPkg::word_t     readData
);
    import lvdcPkg::*;

    word_t mem [memWords];

    // Store has priority; loader is idle during a run anyway.
    always_ff @(posedge clk) begin
        if (storeWrite.enable) begin
            mem[storeWrite.address] <= storeWrite.data;
        end else if (loadWrite.enable) begin
            mem[loadWrite.address] <= loadWrite.data;
        end
    end

    assign readData = mem[readAddr];

endmodule

// ==== src/timingGen.sv ====
module timingGen (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             halt,
    input  logic             haltRequest,
    output lvdcPkg::timing_t timing,
    output logic             running
);
    import lvdcPkg::*;

    logic [bitCountBits-1:0] bitTime;
    logic                    execPhase;
    logic                    wordEnd;
    logic                    stopNow;

    assign wordEnd = running && (bitTime == bitCountBits'(wordBits - 1));
    assign stopNow = wordEnd && execPhase && (halt || haltRequest);

    // ************************************************************
    // Run flip-flop, phase and bit-time counter
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            execPhase <= 1'b0;
            bitTime   <= '0;
        end else if (!running) begin
            running   <= start;
            execPhase <= 1'b0;
            bitTime   <= '0;
        end else if (stopNow) begin
            running   <= 1'b0;  // Stop after the current instruction.
            execPhase <= 1'b0;
            bitTime   <= '0;
        end else if (wordEnd) begin
            execPhase <= ~execPhase;
            bitTime   <= '0;
        end else begin
            bitTime <= bitTime + 1'b1;
        end
    end

    assign timing.running   = running;
    assign timing.execPhase = execPhase;
    assign timing.wordStart = running && (bitTime == '0);
    assign timing.wordEnd   = wordEnd;
    assign timing.bitTime   = bitTime;

endmodule

// ==== src/serialLoader.sv ====
module serialLoader (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               dataIn,
    input  logic               dataValid,
    input  lvdcPkg::timing_t   timing,
    output lvdcPkg::memWrite_t loadWrite
);
    import lvdcPkg::*;

    logic [wordBits-2:0]     shiftReg;
    logic [bitCountBits-1:0] bitCount;
    addr_t                   loadAddr;
    logic                    accept;
    logic                    lastBit;

    assign accept  = dataValid && !timing.running;  // Loading only while halted.
    assign lastBit = (bitCount == bitCountBits'(wordBits - 1));

    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= {dataIn, shiftReg[wordBits-2:1]};  // LSB arrives first.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bitCount  <= '0;
            loadAddr  <= '0;
            loadWrite <= '0;
        end else begin
            loadWrite.enable <= accept && lastBit;
            if (accept) begin
                bitCount <= lastBit ? '0 : bitCount + 1'b1;
                if (lastBit) begin
                    loadWrite.address <= loadAddr;
                    loadWrite.data    <= {dataIn, shiftReg};
                end
            end
            if (start) begin
                loadAddr <= '0;
            end else if (accept && lastBit) begin
                loadAddr <= loadAddr + 1'b1;
            end
        end
    end

endmodule

// ==== src/lvdcPkg.sv ====
package lvdcPkg;

    // ************************************************************
    // Word and memory sizes
    // ************************************************************
    localparam int wordBits     = 13;
    localparam int opBits       = 4;
    localparam int addrBits     = 9;
    localparam int memWords     = 512;
    localparam int bitCountBits = 4;

    // ************************************************************
    // Opcodes
    // ************************************************************
    localparam logic [opBits-1:0] opHalt          = 4'd0;
    localparam logic [opBits-1:0] opClearAdd      = 4'd1;
    localparam logic [opBits-1:0] opAdd           = 4'd2;
    localparam logic [opBits-1:0] opSub           = 4'd3;
    localparam logic [opBits-1:0] opAnd           = 4'd4;
    localparam logic [opBits-1:0] opStore         = 4'd5;
    localparam logic [opBits-1:0] opTransfer      = 4'd6;
    localparam logic [opBits-1:0] opTransferMinus = 4'd7;

    typedef logic [wordBits-1:0] word_t;
    typedef logic [addrBits-1:0] addr_t;
    typedef logic [opBits-1:0]   opcode_t;

    // Opcode sits in the top bits of the word.
    typedef struct packed {
        opcode_t opcode;
        addr_t   address;
    } instr_t;

    typedef struct packed {
        logic  enable;
        addr_t address;
        word_t data;
    } memWrite_t;

    typedef struct packed {
        logic                    running;
        logic                    execPhase;  // 0 is fetch, 1 is execute.
        logic                    wordStart;
        logic                    wordEnd;
        logic [bitCountBits-1:0] bitTime;
    } timing_t;

endpackage
